/* decode_execute.f */
cpu_types_pkg.sv
control_unit.sv
register_file.sv
idecode_iexec.sv
execute_stage.sv
decode_execute.sv
decode_execute_checker.sv
decode_execute_tb.sv

/* Makefile */
TOP := decode_execute_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

# build, run, then decide on the log contents
run:
	verilator --binary --timing -j 0 --top-module $(TOP) -f decode_execute.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing --top-module decode_execute -f decode_execute.f

clean:
	rm -rf obj_dir $(LOG)

/* decode_execute_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_execute_tb;
        import cpu_types_pkg::*;

        // opcode 01 is outside the subset, so decode yields no control
        localparam logic [31:0] bubble_word = 32'h0400_0000;

        logic      CLK = 1'b0;
        logic      nRST;
        instr_u    instr;
        word_t     pcplusfour;
        logic      wb_en;
        regbits_t  wb_sel;
        word_t     wb_data;
        exec_out_t ex;
        int        checks;
        int        errors;
        int        errs_before;
        int        tests_run;
        int        tests_bad;

        // alu functs and immediate ops picked at random
        funct_t     alu_fns [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                                     fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl};
        opcode_t    imm_ops [7]  = '{op_addiu, op_slti, op_sltiu, op_andi,
                                     op_ori, op_xori, op_lui};
        // unused opcodes
        logic [5:0] odd_ops [6]  = '{6'h01, 6'h06, 6'h10, 6'h1c, 6'h20, 6'h3e};
        // halt, jal, lw, sw and j held in decode during reset
        logic [31:0] busy_words [5] = '{32'hfc00_0000, 32'h0c00_0000, 32'h8c00_0000,
                                        32'hac00_0000, 32'h0800_0000};

        // 4 ns period
        always #2 CLK = ~CLK;

        decode_execute u_dut (
                .CLK        (CLK),
                .nRST       (nRST),
                .instr      (instr),
                .pcplusfour (pcplusfour),
                .wb_en      (wb_en),
                .wb_sel     (wb_sel),
                .wb_data    (wb_data),
                .ex         (ex)
        );

        decode_execute_checker u_checker (
                .CLK        (CLK),
                .nRST       (nRST),
                .instr      (instr),
                .pcplusfour (pcplusfour),
                .wb_en      (wb_en),
                .wb_sel     (wb_sel),
                .wb_data    (wb_data),
                .ex         (ex),
                .checks     (checks),
                .errors     (errors)
        );

        function automatic instr_u make_rtype(funct_t fn);
                instr_u w;
                w.r.opcode = op_rtype;
                w.r.rs     = 5'($urandom());
                w.r.rt     = 5'($urandom());
                w.r.rd     = 5'($urandom());
                w.r.shamt  = 5'($urandom());
                w.r.funct  = fn;
                return w;
        endfunction

        function automatic instr_u make_itype(opcode_t op);
                instr_u w;
                w.i.opcode = op;
                w.i.rs     = 5'($urandom());
                w.i.rt     = 5'($urandom());
                w.i.imm    = 16'($urandom());
                return w;
        endfunction

        function automatic instr_u make_jtype(opcode_t op);
                instr_u w;
                w.j.opcode = op;
                w.j.addr   = 26'($urandom());
                return w;
        endfunction

        // new instruction 1 ns after the edge, word-aligned pc
        task automatic issue(instr_u w);
                @(posedge CLK);
                #1;
                instr      = w;
                pcplusfour = $urandom() & 32'hffff_fffc;
                wb_en      = 1'b0;
        endtask

        // one write-back beat while decode sees a bubble
        task automatic write_reg(regbits_t sel, word_t val);
                @(posedge CLK);
                #1;
                instr   = bubble_word;
                wb_en   = 1'b1;
                wb_sel  = sel;
                wb_data = val;
        endtask

        // last issued instruction is compared two checks later
        task automatic drain_checks(output logic stuck);
                int target;
                int waited;
                target = checks + 2;
                waited = 0;
                stuck  = 1'b0;
                while ((checks < target) && (waited < 20)) begin
                        @(posedge CLK);
                        waited++;
                end
                if (checks < target) begin
                        $display("timeout: the checker stopped comparing the DUT output");
                        stuck = 1'b1;
                end
                #1;
        endtask

        task automatic finish_test(string name);
                int   bad;
                logic stuck;
                drain_checks(stuck);
                bad         = errors - errs_before;
                errs_before = errors;
                tests_run++;
                if ((bad != 0) || stuck) begin
                        tests_bad++;
                end
                $display("test %s %s, %0d mismatches", name,
                         ((bad == 0) && !stuck) ? "ok" : "wrong", bad);
        endtask

        initial begin
                instr_u w;
                int     seed;
                seed        = $urandom(32'hb06a);
                nRST        = 1'b0;
                instr       = bubble_word;
                pcplusfour  = '0;
                wb_en       = 1'b0;
                wb_sel      = '0;
                wb_data     = '0;
                errs_before = 0;
                tests_run   = 0;
                tests_bad   = 0;

                // reset for 5 clocks with live opcodes in decode, ex must stay quiet
                for (int k = 0; k < 5; k++) begin
                        instr = busy_words[k];
                        @(posedge CLK);
                        #1;
                end
                nRST  = 1'b1;
                instr = bubble_word;
                finish_test("reset");

                // preload r1..r31
                for (int k = 1; k < 32; k++) begin
                        write_reg(5'(k), $urandom());
                end
                repeat (40) issue(make_rtype(alu_fns[4'($urandom_range(9, 0))]));
                // write to r0 is dropped
                write_reg(5'd0, 32'hdead_beef);
                w = make_rtype(fn_addu);
                w.r.rs = 5'd0;
                issue(w);
                w = make_rtype(fn_or);
                w.r.rt = 5'd0;
                issue(w);
                finish_test("r-type");

                repeat (40) issue(make_itype(imm_ops[3'($urandom_range(6, 0))]));
                finish_test("i-type");

                repeat (20) begin
                        if ($urandom_range(1, 0) == 0) begin
                                issue(make_itype(op_lw));
                        end else begin
                                issue(make_itype(op_sw));
                        end
                end
                finish_test("load-store");

                // r5 == r6, r7 differs
                write_reg(5'd5, 32'h1234_5678);
                write_reg(5'd6, 32'h1234_5678);
                write_reg(5'd7, 32'h8765_4321);
                for (int k = 0; k < 8; k++) begin
                        if (k[0]) begin
                                w = make_itype(op_bne);
                        end else begin
                                w = make_itype(op_beq);
                        end
                        w.i.rs = 5'd5;
                        w.i.rt = k[1] ? 5'd7 : 5'd6;
                        issue(w);
                end
                repeat (8) begin
                        issue(make_jtype(op_j));
                        issue(make_jtype(op_jal));
                        issue(make_rtype(fn_jr));
                end
                finish_test("branch-jump");

                repeat (4) issue(make_itype(op_halt));
                for (int k = 0; k < 6; k++) begin
                        issue(make_itype(opcode_t'(odd_ops[3'(k)])));
                end
                // undefined funct
                issue(make_rtype(funct_t'(6'h3f)));
                finish_test("halt-unknown");

                $display("tests run %0d, tests wrong %0d, checks %0d, mismatches %0d",
                         tests_run, tests_bad, checks, errors);
                if ((errors == 0) && (tests_bad == 0)) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* decode_execute_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_execute_checker (
        input  logic                     CLK,
        input  logic                     nRST,
        input  cpu_types_pkg::instr_u    instr,
        input  cpu_types_pkg::word_t     pcplusfour,
        input  logic                     wb_en,
        input  cpu_types_pkg::regbits_t  wb_sel,
        input  cpu_types_pkg::word_t     wb_data,
        input  cpu_types_pkg::exec_out_t ex,
        output int                       checks,
        output int                       errors
);
        import cpu_types_pkg::*;

        // shadow copy of the architectural registers
        word_t     shadow [32];
        // expected ex for the instruction now in execute
        exec_out_t want_ex   = '0;
        // low while the latch holds a reset bubble
        logic      want_live = 1'b0;
        int        n_checks  = 0;
        int        n_errors  = 0;

        assign checks = n_checks;
        assign errors = n_errors;

        // expected execute output straight from the isa rules
        function automatic exec_out_t ref_exec(instr_u ins, word_t pc4, word_t ra, word_t rb);
                exec_out_t o;
                word_t     simm;
                word_t     zimm;
                logic      taken;
                simm = {{16{ins.i.imm[15]}}, ins.i.imm};
                zimm = {16'h0000, ins.i.imm};
                o            = '0;
                o.next_pc    = pc4;
                o.store_data = rb;
                o.wsel       = ins.i.rt;
                o.reg_wr     = 1'b1;
                case (ins.i.opcode)
                        op_rtype: begin
                                o.wsel = ins.r.rd;
                                case (ins.r.funct)
                                        fn_addu: o.result = ra + rb;
                                        fn_subu: o.result = ra - rb;
                                        fn_and:  o.result = ra & rb;
                                        fn_or:   o.result = ra | rb;
                                        fn_xor:  o.result = ra ^ rb;
                                        fn_nor:  o.result = ~(ra | rb);
                                        fn_slt:  o.result = {31'd0, $signed(ra) < $signed(rb)};
                                        fn_sltu: o.result = {31'd0, ra < rb};
                                        fn_sll:  o.result = rb << ins.r.shamt;
                                        fn_srl:  o.result = rb >> ins.r.shamt;
                                        fn_jr: begin
                                                o.reg_wr   = 1'b0;
                                                o.redirect = 1'b1;
                                                o.next_pc  = ra;
                                        end
                                        default: o.reg_wr = 1'b0;
                                endcase
                        end
                        op_addiu: o.result = ra + simm;
                        op_slti:  o.result = {31'd0, $signed(ra) < $signed(simm)};
                        op_sltiu: o.result = {31'd0, ra < simm};
                        // logic ops zero-extend
                        op_andi:  o.result = ra & zimm;
                        op_ori:   o.result = ra | zimm;
                        op_xori:  o.result = ra ^ zimm;
                        op_lui:   o.result = {ins.i.imm, 16'h0000};
                        op_lw: begin
                                o.result = ra + simm;
                                o.mem_rd = 1'b1;
                        end
                        op_sw: begin
                                o.reg_wr = 1'b0;
                                o.result = ra + simm;
                                o.mem_wr = 1'b1;
                        end
                        op_beq, op_bne: begin
                                o.reg_wr   = 1'b0;
                                taken      = (ins.i.opcode == op_beq) == (ra == rb);
                                o.redirect = taken;
                                if (taken) begin
                                        o.next_pc = pc4 + (simm << 2);
                                end
                        end
                        op_j: begin
                                o.reg_wr   = 1'b0;
                                o.redirect = 1'b1;
                                o.next_pc  = {pc4[31:28], ins.j.addr, 2'b00};
                        end
                        op_jal: begin
                                // link into r31
                                o.wsel     = 5'd31;
                                o.result   = pc4;
                                o.redirect = 1'b1;
                                o.next_pc  = {pc4[31:28], ins.j.addr, 2'b00};
                        end
                        op_halt: begin
                                o.reg_wr = 1'b0;
                                o.halt   = 1'b1;
                        end
                        default: o.reg_wr = 1'b0;
                endcase
                return o;
        endfunction

        task automatic compare_field(string name, logic [31:0] want, logic [31:0] got);
                if (got !== want) begin
                        n_errors = n_errors + 1;
                        $display("error at %0t ns: ex.%s expected %h got %h",
                                 $time, name, want, got);
                end
        endtask

        // predict at the edge, using registers from before this edge's write
        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        shadow    = '{default: '0};
                        want_ex   = '0;
                        want_live = 1'b0;
                end else begin
                        want_ex   = ref_exec(instr, pcplusfour, shadow[instr.i.rs],
                                             shadow[instr.i.rt]);
                        want_live = 1'b1;
                        // r0 stays zero
                        if (wb_en && (wb_sel != 5'd0)) begin
                                shadow[wb_sel] = wb_data;
                        end
                end
        end

        // compare mid-cycle, ex only moves on the rising edge
        always @(negedge CLK) begin
                n_checks = n_checks + 1;
                compare_field("reg_wr", 32'(want_ex.reg_wr), 32'(ex.reg_wr));
                compare_field("mem_rd", 32'(want_ex.mem_rd), 32'(ex.mem_rd));
                compare_field("mem_wr", 32'(want_ex.mem_wr), 32'(ex.mem_wr));
                compare_field("redirect", 32'(want_ex.redirect), 32'(ex.redirect));
                compare_field("halt", 32'(want_ex.halt), 32'(ex.halt));
                // data fields only where they mean something
                if (want_live) begin
                        compare_field("next_pc", want_ex.next_pc, ex.next_pc);
                end
                if (want_ex.reg_wr || want_ex.mem_rd || want_ex.mem_wr) begin
                        compare_field("result", want_ex.result, ex.result);
                end
                if (want_ex.reg_wr) begin
                        compare_field("wsel", 32'(want_ex.wsel), 32'(ex.wsel));
                end
                if (want_ex.mem_wr) begin
                        compare_field("store_data", want_ex.store_data, ex.store_data);
                end
        end

endmodule

`default_nettype wire

/* decode_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_execute (
        input  logic                     CLK,
        input  logic                     nRST,
        input  cpu_types_pkg::instr_u    instr,
        input  cpu_types_pkg::word_t     pcplusfour,
        input  logic                     wb_en,
        input  cpu_types_pkg::regbits_t  wb_sel,
        input  cpu_types_pkg::word_t     wb_data,
        output cpu_types_pkg::exec_out_t ex
);
        import cpu_types_pkg::*;

        ctrl_t ctrl;
        word_t ext_imm;
        word_t rdat1;
        word_t rdat2;
        idex_t id_bundle;
        idex_t ex_bundle;

        // decode side
        control_unit u_control_unit (
                .instr   (instr),
                .ctrl    (ctrl),
                .ext_imm (ext_imm)
        );

        // write port belongs to write-back, outside this slice
        register_file u_register_file (
                .CLK   (CLK),
                .nRST  (nRST),
                .wen   (wb_en),
                .wsel  (wb_sel),
                .rsel1 (instr.i.rs),
                .rsel2 (instr.i.rt),
                .wdat  (wb_data),
                .rdat1 (rdat1),
                .rdat2 (rdat2)
        );

        // bundle for id/ex
        assign id_bundle.ctrl       = ctrl;
        assign id_bundle.pcplusfour = pcplusfour;
        assign id_bundle.rdat1      = rdat1;
        assign id_bundle.rdat2      = rdat2;
        assign id_bundle.ext_imm    = ext_imm;
        assign id_bundle.shamt      = instr.r.shamt;
        assign id_bundle.rt         = instr.i.rt;
        assign id_bundle.rd         = instr.r.rd;
        assign id_bundle.j_addr     = instr.j.addr;

        idecode_iexec u_idecode_iexec (
                .CLK  (CLK),
                .nRST (nRST),
                .id   (id_bundle),
                .ex   (ex_bundle)
        );

        // execute side
        execute_stage u_execute_stage (
                .ex_in  (ex_bundle),
                .ex_out (ex)
        );

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
        input  cpu_types_pkg::idex_t     ex_in,
        output cpu_types_pkg::exec_out_t ex_out
);
        import cpu_types_pkg::*;

        word_t op_a;
        word_t op_b;
        word_t alu_val;
        word_t br_target;
        word_t j_target;
        logic  equal;
        logic  br_taken;

        // operand select
        assign op_a = ex_in.rdat1;
        assign op_b = ex_in.ctrl.alu_src ? ex_in.ext_imm : ex_in.rdat2;

        // alu
        always_comb begin
                case (ex_in.ctrl.alu_ctr)
                        alu_add:  alu_val = op_a + op_b;
                        alu_sub:  alu_val = op_a - op_b;
                        alu_and:  alu_val = op_a & op_b;
                        alu_or:   alu_val = op_a | op_b;
                        alu_xor:  alu_val = op_a ^ op_b;
                        alu_nor:  alu_val = ~(op_a | op_b);
                        alu_slt:  alu_val = {31'd0, $signed(op_a) < $signed(op_b)};
                        alu_sltu: alu_val = {31'd0, op_a < op_b};
                        // shifts act on rt by shamt
                        alu_sll:  alu_val = ex_in.rdat2 << ex_in.shamt;
                        alu_srl:  alu_val = ex_in.rdat2 >> ex_in.shamt;
                        default:  alu_val = '0;
                endcase
        end

        // branch compare on the raw register values
        assign equal    = (ex_in.rdat1 == ex_in.rdat2);
        assign br_taken = (ex_in.ctrl.beq && equal) || (ex_in.ctrl.bne && !equal);

        // pc+4 plus word offset
        assign br_target = ex_in.pcplusfour + {ex_in.ext_imm[29:0], 2'b00};
        // region bits kept from pc+4
        assign j_target  = {ex_in.pcplusfour[31:28], ex_in.j_addr, 2'b00};

        always_comb begin
                // result mux, lui and jal override the alu
                if (ex_in.ctrl.lui) begin
                        ex_out.result = {ex_in.ext_imm[15:0], 16'h0000};
                end else if (ex_in.ctrl.jal) begin
                        ex_out.result = ex_in.pcplusfour;
                end else begin
                        ex_out.result = alu_val;
                end

                // destination
                if (ex_in.ctrl.jal) begin
                        ex_out.wsel = 5'd31;
                end else if (ex_in.ctrl.reg_dst) begin
                        ex_out.wsel = ex_in.rd;
                end else begin
                        ex_out.wsel = ex_in.rt;
                end

                // redirect
                ex_out.redirect = br_taken || ex_in.ctrl.jump || ex_in.ctrl.jr;
                if (ex_in.ctrl.jr) begin
                        ex_out.next_pc = ex_in.rdat1;
                end else if (ex_in.ctrl.jump) begin
                        ex_out.next_pc = j_target;
                end else if (br_taken) begin
                        ex_out.next_pc = br_target;
                end else begin
                        ex_out.next_pc = ex_in.pcplusfour;
                end

                // straight through to mem and wb
                ex_out.store_data = ex_in.rdat2;
                ex_out.mem_rd     = ex_in.ctrl.mem_rd;
                ex_out.mem_wr     = ex_in.ctrl.mem_wr;
                ex_out.reg_wr     = ex_in.ctrl.reg_wr;
                ex_out.halt       = ex_in.ctrl.halt;
        end

endmodule

`default_nettype wire

/* idecode_iexec.sv */
`timescale 1ns/100ps
`default_nettype none

module idecode_iexec (
        input  logic                 CLK,
        input  logic                 nRST,
        input  cpu_types_pkg::idex_t id,
        output cpu_types_pkg::idex_t ex
);

        // id/ex pipeline register
        // loads every edge, no stall or flush in this slice
        // reset empties it so the first cycle is a bubble
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        ex <= '0;
                end else begin
                        // whole bundle in one go
                        // mem_rd and mem_wr each latched from their own bit
                        ex <= id;
                end
        end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
        input  logic                   CLK,
        input  logic                   nRST,
        input  logic                   wen,
        input  cpu_types_pkg::regbits_t wsel,
        input  cpu_types_pkg::regbits_t rsel1,
        input  cpu_types_pkg::regbits_t rsel2,
        input  cpu_types_pkg::word_t    wdat,
        output cpu_types_pkg::word_t    rdat1,
        output cpu_types_pkg::word_t    rdat2
);
        import cpu_types_pkg::*;

        // 32 architectural registers
        word_t regs [32];

        // write on the edge, register zero never written
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wen && (wsel != 5'd0)) begin
                        regs[wsel] <= wdat;
                end
        end

        // combinational reads, no same-cycle bypass
        assign rdat1 = (rsel1 == 5'd0) ? '0 : regs[rsel1];
        assign rdat2 = (rsel2 == 5'd0) ? '0 : regs[rsel2];

endmodule

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
        input  cpu_types_pkg::instr_u instr,
        output cpu_types_pkg::ctrl_t  ctrl,
        output cpu_types_pkg::word_t  ext_imm
);
        import cpu_types_pkg::*;

        // andi/ori/xori take a zero-extended immediate
        logic zero_ext;

        always_comb begin
                // unknown encodings fall out as all zero
                ctrl     = '0;
                zero_ext = 1'b0;
                case (instr.i.opcode)
                        op_rtype: begin
                                ctrl.reg_dst = 1'b1;
                                ctrl.reg_wr  = 1'b1;
                                // funct comes from the r-type view
                                case (instr.r.funct)
                                        fn_addu: ctrl.alu_ctr = alu_add;
                                        fn_subu: ctrl.alu_ctr = alu_sub;
                                        fn_and:  ctrl.alu_ctr = alu_and;
                                        fn_or:   ctrl.alu_ctr = alu_or;
                                        fn_xor:  ctrl.alu_ctr = alu_xor;
                                        fn_nor:  ctrl.alu_ctr = alu_nor;
                                        fn_slt:  ctrl.alu_ctr = alu_slt;
                                        fn_sltu: ctrl.alu_ctr = alu_sltu;
                                        fn_sll:  ctrl.alu_ctr = alu_sll;
                                        fn_srl:  ctrl.alu_ctr = alu_srl;
                                        fn_jr: begin
                                                // jr only redirects, no write
                                                ctrl = '0;
                                                ctrl.jr = 1'b1;
                                        end
                                        default: ctrl = '0;
                                endcase
                        end
                        op_addiu: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_add;
                        end
                        op_slti: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_slt;
                        end
                        op_sltiu: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_sltu;
                        end
                        op_andi: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_and;
                                zero_ext     = 1'b1;
                        end
                        op_ori: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_or;
                                zero_ext     = 1'b1;
                        end
                        op_xori: begin
                                ctrl.reg_wr  = 1'b1;
                                ctrl.alu_src = 1'b1;
                                ctrl.alu_ctr = alu_xor;
                                zero_ext     = 1'b1;
                        end
                        op_lui: begin
                                ctrl.reg_wr = 1'b1;
                                ctrl.lui    = 1'b1;
                        end
                        op_lw: begin
                                // address is rs + sign-extended offset
                                ctrl.reg_wr     = 1'b1;
                                ctrl.alu_src    = 1'b1;
                                ctrl.mem_rd     = 1'b1;
                                ctrl.mem_to_reg = 1'b1;
                        end
                        op_sw: begin
                                ctrl.alu_src = 1'b1;
                                ctrl.mem_wr  = 1'b1;
                        end
                        op_beq: begin
                                ctrl.beq     = 1'b1;
                                ctrl.alu_ctr = alu_sub;
                        end
                        op_bne: begin
                                ctrl.bne     = 1'b1;
                                ctrl.alu_ctr = alu_sub;
                        end
                        op_j:    ctrl.jump = 1'b1;
                        op_jal: begin
                                // destination forced to r31 in execute
                                ctrl.jump   = 1'b1;
                                ctrl.jal    = 1'b1;
                                ctrl.reg_wr = 1'b1;
                        end
                        op_halt: ctrl.halt = 1'b1;
                        default: ctrl = '0;
                endcase
        end

        // immediate extension
        assign ext_imm = zero_ext ? {16'h0000, instr.i.imm} :
                                    {{16{instr.i.imm[15]}}, instr.i.imm};

endmodule

`default_nettype wire

/* cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

        // basic widths, all fixed by the isa
        typedef logic [31:0] word_t;
        typedef logic [4:0]  regbits_t;

        // primary opcodes of the supported subset
        typedef enum logic [5:0] {
                op_rtype = 6'h00,
                op_j     = 6'h02,
                op_jal   = 6'h03,
                op_beq   = 6'h04,
                op_bne   = 6'h05,
                op_addiu = 6'h09,
                op_slti  = 6'h0a,
                op_sltiu = 6'h0b,
                op_andi  = 6'h0c,
                op_ori   = 6'h0d,
                op_xori  = 6'h0e,
                op_lui   = 6'h0f,
                op_lw    = 6'h23,
                op_sw    = 6'h2b,
                op_halt  = 6'h3f
        } opcode_t;

        // r-type funct field
        typedef enum logic [5:0] {
                fn_sll  = 6'h00,
                fn_srl  = 6'h02,
                fn_jr   = 6'h08,
                fn_addu = 6'h21,
                fn_subu = 6'h23,
                fn_and  = 6'h24,
                fn_or   = 6'h25,
                fn_xor  = 6'h26,
                fn_nor  = 6'h27,
                fn_slt  = 6'h2a,
                fn_sltu = 6'h2b
        } funct_t;

        // alu_add is zero so an all-zero ctrl_t is a clean bubble
        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor,
                alu_nor, alu_slt, alu_sltu, alu_sll, alu_srl
        } aluop_t;

        // the three instruction formats
        typedef struct packed {
                opcode_t     opcode;
                regbits_t    rs;
                regbits_t    rt;
                regbits_t    rd;
                logic [4:0]  shamt;
                funct_t      funct;
        } r_type_t;

        typedef struct packed {
                opcode_t     opcode;
                regbits_t    rs;
                regbits_t    rt;
                logic [15:0] imm;
        } i_type_t;

        typedef struct packed {
                opcode_t     opcode;
                logic [25:0] addr;
        } j_type_t;

        // one fetched word, three views
        typedef union packed {
                r_type_t r;
                i_type_t i;
                j_type_t j;
        } instr_u;

        // decoded control bits
        typedef struct packed {
                logic   reg_wr;
                logic   reg_dst;
                logic   alu_src;
                aluop_t alu_ctr;
                logic   mem_wr;
                logic   mem_rd;
                logic   mem_to_reg;
                logic   beq;
                logic   bne;
                logic   jump;
                logic   jal;
                logic   jr;
                logic   lui;
                logic   halt;
        } ctrl_t;

        // bundle held in the id/ex register
        typedef struct packed {
                ctrl_t       ctrl;
                word_t       pcplusfour;
                word_t       rdat1;
                word_t       rdat2;
                word_t       ext_imm;
                logic [4:0]  shamt;
                regbits_t    rt;
                regbits_t    rd;
                logic [25:0] j_addr;
        } idex_t;

        // everything execute hands to the later stages
        typedef struct packed {
                word_t    result;
                word_t    store_data;
                logic     mem_rd;
                logic     mem_wr;
                logic     reg_wr;
                regbits_t wsel;
                logic     redirect;
                word_t    next_pc;
                logic     halt;
        } exec_out_t;

endpackage

`default_nettype wire
